/* Makefile */
# Verilator build and run for the SoC peripheral testbench

VERILATOR ?= verilator
TOP       ?= tb_soc
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -qx "Regression passed"

clean:
	rm -rf $(OBJ_DIR)

/* all.f */
rtl/soc_pkg.sv
rtl/ahb_interconnect.sv
rtl/ahb_ram.sv
rtl/ahb_gpio.sv
rtl/ahb_uart.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/soc_periph_top.sv
test/soc_assert.sv
test/tb_soc.sv

/* rtl/ahb_gpio.sv */
`timescale 1ns/1ps

module ahb_gpio
#(
    parameter int GPIO_WIDTH = 32
)
(
    input  logic                  clk,
    input  logic                  RSTn,
    input  logic                  sel,
    input  logic [31:0]           haddr,
    input  soc_pkg::htrans_t      htrans,
    input  logic [2:0]            hsize,
    input  logic                  hwrite,
    input  logic [31:0]           hwdata,
    input  logic [GPIO_WIDTH-1:0] gpio_in,
    output logic [31:0]           rdata,
    output logic [GPIO_WIDTH-1:0] gpio_out,
    output logic [GPIO_WIDTH-1:0] gpio_oe
);

    logic                  addr_phase;
    logic                  wr_q;
    logic [3:0]            ofs_q;           // Word aligned register offset
    logic [3:0]            lanes_q;
    logic [31:0]           lane_mask;
    logic [GPIO_WIDTH-1:0] wmask;
    logic [GPIO_WIDTH-1:0] out_q, oe_q;
    logic [GPIO_WIDTH-1:0] in_meta, in_sync; // Two flop synchroniser

    assign addr_phase = sel && ((htrans == soc_pkg::TRANS_NONSEQ)
                                || (htrans == soc_pkg::TRANS_SEQ));

    always_ff @(posedge clk)
    begin
        if (addr_phase)
        begin
            ofs_q   <= {haddr[3:2], 2'b00};
            lanes_q <= soc_pkg::byte_lanes(hsize, haddr[1:0]);
        end
    end

    assign lane_mask = {{8{lanes_q[3]}}, {8{lanes_q[2]}}, {8{lanes_q[1]}}, {8{lanes_q[0]}}};
    assign wmask     = lane_mask[GPIO_WIDTH-1:0];

    // --------------------------------------------------
    // Control registers and input sync
    // --------------------------------------------------
    always_ff @(posedge clk or negedge RSTn)
    begin
        if (!RSTn)
        begin
            wr_q    <= 1'b0;
            out_q   <= '0;
            oe_q    <= '0;
            in_meta <= '0;
            in_sync <= '0;
        end
        else
        begin
            wr_q    <= addr_phase && hwrite;
            in_meta <= gpio_in;
            in_sync <= in_meta;
            if (wr_q && ofs_q == soc_pkg::GPIO_OUT_OFS)
                out_q <= (out_q & ~wmask) | (hwdata[GPIO_WIDTH-1:0] & wmask);
            if (wr_q && ofs_q == soc_pkg::GPIO_OE_OFS)
                oe_q <= (oe_q & ~wmask) | (hwdata[GPIO_WIDTH-1:0] & wmask);
        end
    end

    // Read mux on registered offset, zero extended
    always_comb
    begin
        rdata = '0;
        case (ofs_q)
            soc_pkg::GPIO_OUT_OFS: rdata[GPIO_WIDTH-1:0] = out_q;
            soc_pkg::GPIO_OE_OFS:  rdata[GPIO_WIDTH-1:0] = oe_q;
            soc_pkg::GPIO_IN_OFS:  rdata[GPIO_WIDTH-1:0] = in_sync;
            default:               rdata = '0;
        endcase
    end

    assign gpio_out = out_q;
    assign gpio_oe  = oe_q;

endmodule

/* rtl/ahb_interconnect.sv */
`timescale 1ns/1ps

module ahb_interconnect
(
    input  logic             clk,
    input  logic             RSTn,
    input  logic [31:0]      haddr,
    input  soc_pkg::htrans_t htrans,
    input  logic [31:0]      rdata_code,
    input  logic [31:0]      rdata_data,
    input  logic [31:0]      rdata_gpio,
    input  logic [31:0]      rdata_uart,
    output logic             sel_code,
    output logic             sel_data,
    output logic             sel_gpio,
    output logic             sel_uart,
    output logic [31:0]      hrdata
);

    logic       active;     // NONSEQ or SEQ in this cycle
    logic [3:0] region;
    logic [3:0] dsel_q;     // Data phase owner, one-hot {uart, gpio, data, code}

    // --------------------------------------------------
    // Address phase decode
    // --------------------------------------------------
    assign active = (htrans == soc_pkg::TRANS_NONSEQ) || (htrans == soc_pkg::TRANS_SEQ);
    assign region = haddr[31:28];

    assign sel_code = active && (region == soc_pkg::REGION_RAM_CODE);
    assign sel_data = active && (region == soc_pkg::REGION_RAM_DATA);
    // Peripheral window split on a single address bit
    assign sel_gpio = active && (region == soc_pkg::REGION_PERIPH)
                      && !haddr[soc_pkg::PERIPH_SEL_BIT];
    assign sel_uart = active && (region == soc_pkg::REGION_PERIPH)
                      && haddr[soc_pkg::PERIPH_SEL_BIT];

    // Owner of the coming data phase, all zero after idle or unmapped
    always_ff @(posedge clk or negedge RSTn)
    begin
        if (!RSTn)
            dsel_q <= '0;
        else
            dsel_q <= {sel_uart, sel_gpio, sel_data, sel_code};
    end

    // --------------------------------------------------
    // Data phase read mux
    // --------------------------------------------------
    always_comb
    begin
        case (dsel_q)
            4'b0001: hrdata = rdata_code;
            4'b0010: hrdata = rdata_data;
            4'b0100: hrdata = rdata_gpio;
            4'b1000: hrdata = rdata_uart;
            default: hrdata = '0;           // Unmapped or no transfer
        endcase
    end

endmodule

/* rtl/ahb_ram.sv */
`timescale 1ns/1ps

module ahb_ram
#(
    parameter int RAM_WORDS = 1024
)
(
    input  logic             clk,
    input  logic             RSTn,
    input  logic             sel,
    input  logic [31:0]      haddr,
    input  soc_pkg::htrans_t htrans,
    input  logic [2:0]       hsize,
    input  logic             hwrite,
    input  logic [31:0]      hwdata,
    output logic [31:0]      rdata
);

    localparam int AW = $clog2(RAM_WORDS);      // Word address width

    logic [31:0]   mem [RAM_WORDS];
    logic          addr_phase;
    logic          wr_q;                        // Write pending in data phase
    logic [AW-1:0] addr_q;
    logic [3:0]    lanes_q;

    assign addr_phase = sel && ((htrans == soc_pkg::TRANS_NONSEQ)
                                || (htrans == soc_pkg::TRANS_SEQ));

    // --------------------------------------------------
    // Address phase capture
    // --------------------------------------------------
    always_ff @(posedge clk or negedge RSTn)
    begin
        if (!RSTn)
            wr_q <= 1'b0;
        else
            wr_q <= addr_phase && hwrite;       // Cleared on idle cycles
    end

    always_ff @(posedge clk)
    begin
        if (addr_phase)
        begin
            addr_q  <= haddr[AW+1:2];
            lanes_q <= soc_pkg::byte_lanes(hsize, haddr[1:0]);
        end
    end

    // Data phase write, enabled lanes only
    always_ff @(posedge clk)
    begin
        if (wr_q)
        begin
            for (int i = 0; i < 4; i++)
                if (lanes_q[i])
                    mem[addr_q][8*i +: 8] <= hwdata[8*i +: 8];
        end
    end

    assign rdata = mem[addr_q];                 // Async read at registered address

endmodule

/* rtl/ahb_uart.sv */
`timescale 1ns/1ps

module ahb_uart
(
    input  logic             clk,
    input  logic             RSTn,
    input  logic             sel,
    input  logic [31:0]      haddr,
    input  soc_pkg::htrans_t htrans,
    input  logic             hwrite,
    input  logic [31:0]      hwdata,
    input  logic             tx_busy,
    input  logic             rx_valid,
    input  logic [7:0]       rx_byte,
    output logic [31:0]      rdata,
    output logic             tx_start,
    output logic [7:0]       tx_byte,
    output logic             rx_clear
);

    logic       addr_phase;
    logic       wr_q;           // Write data phase
    logic       rd_q;           // Read data phase
    logic [3:0] ofs_q;

    assign addr_phase = sel && ((htrans == soc_pkg::TRANS_NONSEQ)
                                || (htrans == soc_pkg::TRANS_SEQ));

    // --------------------------------------------------
    // Address phase capture
    // --------------------------------------------------
    always_ff @(posedge clk or negedge RSTn)
    begin
        if (!RSTn)
        begin
            wr_q <= 1'b0;
            rd_q <= 1'b0;
        end
        else
        begin
            wr_q <= addr_phase && hwrite;
            rd_q <= addr_phase && !hwrite;
        end
    end

    always_ff @(posedge clk)
    begin
        if (addr_phase)
            ofs_q <= {haddr[3:2], 2'b00};
    end

    // Transmit pulse, dropped while the line is busy
    assign tx_start = wr_q && (ofs_q == soc_pkg::UART_DATA_OFS) && !tx_busy;
    assign tx_byte  = hwdata[7:0];              // Valid in the write data phase

    // Reading the data register acknowledges the byte
    assign rx_clear = rd_q && (ofs_q == soc_pkg::UART_DATA_OFS);

    always_comb
    begin
        case (ofs_q)
            soc_pkg::UART_DATA_OFS: rdata = {24'b0, rx_byte};
            soc_pkg::UART_STAT_OFS: rdata = {30'b0, rx_valid, tx_busy};
            default:                rdata = '0;
        endcase
    end

endmodule

/* rtl/soc_periph_top.sv */
`timescale 1ns/1ps

module soc_periph_top
#(
    parameter int RAM_WORDS    = 1024,
    parameter int GPIO_WIDTH   = 32,
    parameter int CLKS_PER_BIT = 16
)
(
    input  logic                  clk,
    input  logic                  RSTn,
    input  logic [31:0]           haddr,
    input  soc_pkg::htrans_t      htrans,
    input  logic [2:0]            hsize,
    input  logic                  hwrite,
    input  logic [31:0]           hwdata,
    input  logic                  rxd,
    input  logic [GPIO_WIDTH-1:0] gpio_in,
    output logic [31:0]           hrdata,
    output logic                  txd,
    output logic                  irq,
    output logic [GPIO_WIDTH-1:0] gpio_out,
    output logic [GPIO_WIDTH-1:0] gpio_oe
);

    logic        sel_code, sel_data, sel_gpio, sel_uart;
    logic [31:0] rdata_code, rdata_data, rdata_gpio, rdata_uart;
    logic        tx_start, tx_busy, rx_valid, rx_clear;
    logic [7:0]  tx_byte, rx_byte;

    // --------------------------------------------------
    // Bus fabric and memories
    // --------------------------------------------------
    ahb_interconnect u_interconnect (.clk, .RSTn, .haddr, .htrans,
        .rdata_code, .rdata_data, .rdata_gpio, .rdata_uart,
        .sel_code, .sel_data, .sel_gpio, .sel_uart, .hrdata);

    ahb_ram #(.RAM_WORDS(RAM_WORDS)) u_ram_code (.clk, .RSTn, .sel(sel_code),
        .haddr, .htrans, .hsize, .hwrite, .hwdata, .rdata(rdata_code));

    ahb_ram #(.RAM_WORDS(RAM_WORDS)) u_ram_data (.clk, .RSTn, .sel(sel_data),
        .haddr, .htrans, .hsize, .hwrite, .hwdata, .rdata(rdata_data));

    // --------------------------------------------------
    // Peripherals
    // --------------------------------------------------
    ahb_gpio #(.GPIO_WIDTH(GPIO_WIDTH)) u_gpio (.clk, .RSTn, .sel(sel_gpio),
        .haddr, .htrans, .hsize, .hwrite, .hwdata, .gpio_in,
        .rdata(rdata_gpio), .gpio_out, .gpio_oe);

    ahb_uart u_uart (.clk, .RSTn, .sel(sel_uart), .haddr, .htrans, .hwrite, .hwdata,
        .tx_busy, .rx_valid, .rx_byte, .rdata(rdata_uart),
        .tx_start, .tx_byte, .rx_clear);

    // Each direction counts its own baud ticks
    uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart_tx (.clk, .RSTn,
        .tx_start, .tx_byte, .txd, .tx_busy);

    uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart_rx (.clk, .RSTn,
        .rxd, .rx_clear, .rx_byte, .rx_valid);

    assign irq = rx_valid;          // Receive data pending

endmodule

/* rtl/soc_pkg.sv */
package soc_pkg;

    // --------------------------------------------------
    // AHB transfer type
    // --------------------------------------------------
    typedef enum logic [1:0] {
        TRANS_IDLE   = 2'b00,   // No transfer
        TRANS_BUSY   = 2'b01,   // Master pause inside a burst
        TRANS_NONSEQ = 2'b10,   // Single or first beat
        TRANS_SEQ    = 2'b11    // Following beats of a burst
    } htrans_t;

    // Memory map, HADDR[31:28]
    localparam logic [3:0] REGION_RAM_CODE = 4'h0;
    localparam logic [3:0] REGION_RAM_DATA = 4'h2;
    localparam logic [3:0] REGION_PERIPH   = 4'h4;
    localparam int         PERIPH_SEL_BIT  = 12;    // 0 GPIO, 1 UART

    // Register offsets inside each peripheral
    localparam logic [3:0] GPIO_OUT_OFS  = 4'h0;
    localparam logic [3:0] GPIO_OE_OFS   = 4'h4;
    localparam logic [3:0] GPIO_IN_OFS   = 4'h8;    // Read only
    localparam logic [3:0] UART_DATA_OFS = 4'h0;
    localparam logic [3:0] UART_STAT_OFS = 4'h4;

    // Byte write mask from HSIZE and HADDR[1:0]
    function automatic logic [3:0] byte_lanes(input logic [2:0] size, input logic [1:0] addr);
        case (size)
            3'b000:  return 4'b0001 << addr;                 // Byte
            3'b001:  return addr[1] ? 4'b1100 : 4'b0011;     // Halfword
            default: return 4'b1111;                         // Word and wider
        endcase
    endfunction

endpackage

/* rtl/uart_rx.sv */
`timescale 1ns/1ps

module uart_rx
#(
    parameter int CLKS_PER_BIT = 16
)
(
    input  logic       clk,
    input  logic       RSTn,
    input  logic       rxd,
    input  logic       rx_clear,
    output logic [7:0] rx_byte,
    output logic       rx_valid
);

    localparam int            CW   = $clog2(CLKS_PER_BIT);
    localparam logic [CW-1:0] LAST = CW'(CLKS_PER_BIT - 1);
    localparam logic [CW-1:0] HALF = CW'(CLKS_PER_BIT / 2 - 1);   // Start bit middle

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

    rx_state_t     state_q;
    logic          rx_meta, rx_s;   // Line synchroniser
    logic [CW-1:0] cnt_q;
    logic [2:0]    bit_q;
    logic [7:0]    shift_q;
    logic          sample;          // Middle of the current bit

    assign sample = (state_q == RX_START) ? (cnt_q == HALF) : (cnt_q == LAST);

    always_ff @(posedge clk or negedge RSTn)
    begin
        if (!RSTn)
        begin
            rx_meta  <= 1'b1;
            rx_s     <= 1'b1;
            state_q  <= RX_IDLE;
            cnt_q    <= '0;
            bit_q    <= '0;
            rx_byte  <= '0;
            rx_valid <= 1'b0;
        end
        else
        begin
            rx_meta <= rxd;
            rx_s    <= rx_meta;
            if (rx_clear)
                rx_valid <= 1'b0;               // A new byte below wins
            case (state_q)
                RX_IDLE:  if (!rx_s) state_q <= RX_START;
                RX_START: if (sample) state_q <= rx_s ? RX_IDLE : RX_DATA;  // Glitch check
                RX_DATA:
                begin
                    if (sample)
                    begin
                        bit_q <= bit_q + 3'd1;
                        if (bit_q == 3'd7)
                            state_q <= RX_STOP;
                    end
                end
                RX_STOP:
                begin
                    if (sample)
                    begin
                        state_q <= RX_IDLE;
                        if (rx_s)               // Framing error drops the byte
                        begin
                            rx_byte  <= shift_q;
                            rx_valid <= 1'b1;
                        end
                    end
                end
                default: state_q <= RX_IDLE;
            endcase
            cnt_q <= (state_q == RX_IDLE || sample) ? '0 : cnt_q + 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (state_q == RX_DATA && sample)
            shift_q <= {rx_s, shift_q[7:1]};    // LSB arrives first
    end

endmodule

/* rtl/uart_tx.sv */
`timescale 1ns/1ps

module uart_tx
#(
    parameter int CLKS_PER_BIT = 16
)
(
    input  logic       clk,
    input  logic       RSTn,
    input  logic       tx_start,
    input  logic [7:0] tx_byte,
    output logic       txd,
    output logic       tx_busy
);

    localparam int            CW   = $clog2(CLKS_PER_BIT);
    localparam logic [CW-1:0] LAST = CW'(CLKS_PER_BIT - 1);

    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;

    tx_state_t     state_q;
    logic [CW-1:0] cnt_q;           // Baud counter
    logic [2:0]    bit_q;           // Data bit index
    logic [7:0]    shift_q;
    logic          bit_end;

    assign bit_end = (cnt_q == LAST);

    always_ff @(posedge clk or negedge RSTn)
    begin
        if (!RSTn)
        begin
            state_q <= TX_IDLE;
            cnt_q   <= '0;
            bit_q   <= '0;
        end
        else
        begin
            case (state_q)
                TX_IDLE:  if (tx_start) state_q <= TX_START;
                TX_START: if (bit_end) state_q <= TX_DATA;
                TX_DATA:
                begin
                    if (bit_end)
                    begin
                        bit_q <= bit_q + 3'd1;              // Wraps to 0 after bit 7
                        if (bit_q == 3'd7)
                            state_q <= TX_STOP;
                    end
                end
                TX_STOP:  if (bit_end) state_q <= TX_IDLE;
                default:  state_q <= TX_IDLE;
            endcase
            // Counter free runs only inside a frame
            cnt_q <= (state_q == TX_IDLE || bit_end) ? '0 : cnt_q + 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (state_q == TX_IDLE && tx_start)
            shift_q <= tx_byte;
        else if (state_q == TX_DATA && bit_end)
            shift_q <= {1'b0, shift_q[7:1]};            // LSB first
    end

    assign txd     = (state_q == TX_START) ? 1'b0 :
                     (state_q == TX_DATA)  ? shift_q[0] : 1'b1;    // Idle and stop high
    assign tx_busy = (state_q != TX_IDLE);

endmodule

/* test/soc_assert.sv */
`timescale 1ns/1ps

module soc_assert
(
    input logic       clk,
    input logic       RSTn,
    input logic [1:0] htrans,
    input logic       sel_code,
    input logic       sel_data,
    input logic       sel_gpio,
    input logic       sel_uart,
    input logic       txd,
    input logic       tx_busy,
    input logic       irq,
    input logic       rx_clear
);

    // --------------------------------------------------
    // Bus decode and UART line rules
    // --------------------------------------------------
    a_one_sel: assert property (@(posedge clk) disable iff (!RSTn)
        $onehot0({sel_uart, sel_gpio, sel_data, sel_code})) else $error("Several selects high");

    a_txd_idle: assert property (@(posedge clk) disable iff (!RSTn)
        !tx_busy |-> txd) else $error("txd low while transmitter idle");

    a_irq_clear: assert property (@(posedge clk) disable iff (!RSTn)
        rx_clear |-> !$rose(irq)) else $error("irq rose during receive clear");

    a_htrans_known: assert property (@(posedge clk) disable iff (!RSTn)
        !$isunknown(htrans)) else $error("htrans unknown");

endmodule

bind soc_periph_top soc_assert u_assert (.clk, .RSTn, .htrans, .sel_code, .sel_data,
    .sel_gpio, .sel_uart, .txd, .tx_busy, .irq, .rx_clear);

/* test/tb_soc.sv */
`timescale 1ns/1ps

module tb_soc;

    localparam int CLKS_PER_BIT = 8;
    localparam int FRAMES       = 10;       // UART frame slots over both UART tests
    localparam int WATCHDOG_NS  = FRAMES * 10 * CLKS_PER_BIT * 8 + 20000;

    localparam logic [31:0] CODE_BASE = {soc_pkg::REGION_RAM_CODE, 28'h0};
    localparam logic [31:0] DATA_BASE = {soc_pkg::REGION_RAM_DATA, 28'h0};
    localparam logic [31:0] GPIO_BASE = {soc_pkg::REGION_PERIPH, 28'h0};
    localparam logic [31:0] UART_BASE = {soc_pkg::REGION_PERIPH, 28'h000_1000};
    localparam logic [31:0] HOLE_BASE = 32'h1000_0000;     // Region 0x1 has no slave

    logic             clk;
    logic             RSTn;
    logic [31:0]      haddr;
    soc_pkg::htrans_t htrans;
    logic [2:0]       hsize;
    logic             hwrite;
    logic [31:0]      hwdata;
    logic             rxd;
    logic [31:0]      gpio_in;
    logic [31:0]      hrdata;
    logic             txd;
    logic             irq;
    logic [31:0]      gpio_out;
    logic [31:0]      gpio_oe;

    logic [31:0] seed;
    int          errors;
    int          checks;
    int          tests;
    logic [31:0] ref_code [16];             // Model of the low 16 words of each RAM
    logic [31:0] ref_data [16];

    soc_periph_top #(.CLKS_PER_BIT(CLKS_PER_BIT)) dut (.clk, .RSTn, .haddr, .htrans, .hsize,
        .hwrite, .hwdata, .rxd, .gpio_in, .hrdata, .txd, .irq, .gpio_out, .gpio_oe);

    always #4 clk = ~clk;                   // 8 ns period

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------
    function automatic logic [31:0] next_rand();
        seed = seed ^ (seed << 13);         // xorshift32
        seed = seed ^ (seed >> 17);
        seed = seed ^ (seed << 5);
        return seed;
    endfunction

    // Byte lanes written by one transfer
    function automatic logic [3:0] lanes_for(input logic [2:0] size, input logic [1:0] ofs);
        logic [3:0] mask;
        int         first;
        int         count;
        first = int'(ofs);
        count = 1 << size;                  // Bytes in the transfer
        mask  = '0;
        for (int i = 0; i < 4; i++)
            if (i >= first && i < first + count)
                mask[i] = 1'b1;
        return mask;
    endfunction

    function automatic logic [31:0] merge_lanes(input logic [31:0] old_w,
                                                input logic [31:0] wdata,
                                                input logic [3:0]  mask);
        logic [31:0] res;
        res = old_w;
        for (int i = 0; i < 4; i++)
            if (mask[i])
                res[8*i +: 8] = wdata[8*i +: 8];
        return res;
    endfunction

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("MISMATCH at %0t ns: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int start_errs);
        tests++;
        $display("%s finished with %0d errors", name, errors - start_errs);
    endtask

    // Address phase at a falling edge, data phase one cycle later
    task automatic bus_write(input logic [31:0] addr, input logic [2:0] size,
                             input logic [31:0] data);
        @(negedge clk);
        haddr  = addr;
        htrans = soc_pkg::TRANS_NONSEQ;
        hsize  = size;
        hwrite = 1'b1;
        @(negedge clk);
        htrans = soc_pkg::TRANS_IDLE;       // Write lands at the next rising edge
        hwrite = 1'b0;
        hwdata = data;
    endtask

    task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
        @(negedge clk);
        haddr  = addr;
        htrans = soc_pkg::TRANS_NONSEQ;
        hsize  = 3'd2;
        hwrite = 1'b0;
        @(negedge clk);
        htrans = soc_pkg::TRANS_IDLE;
        data   = hrdata;                    // Mid data phase
    endtask

    // Write data phase overlaps the read address phase
    task automatic write_then_read(input logic [31:0] addr, input logic [31:0] wdata,
                                   output logic [31:0] rdata);
        @(negedge clk);
        haddr  = addr;
        htrans = soc_pkg::TRANS_NONSEQ;
        hsize  = 3'd2;
        hwrite = 1'b1;
        @(negedge clk);
        hwdata = wdata;
        hwrite = 1'b0;
        @(negedge clk);
        htrans = soc_pkg::TRANS_IDLE;
        rdata  = hrdata;
    endtask

    // Start and data bits, then leaves rxd at the stop level
    task automatic send_frame(input logic [7:0] data, input logic stop);
        logic [8:0] bits;
        bits = {data, 1'b0};
        for (int i = 0; i < 9; i++)
        begin
            rxd = bits[i];
            repeat (CLKS_PER_BIT) @(negedge clk);
        end
        rxd = stop;
    endtask

    // --------------------------------------------------
    // Tests
    // --------------------------------------------------
    task automatic ram_access();
        int          start_errs;
        logic [31:0] r, data, got;
        logic [3:0]  word;
        logic [2:0]  size;
        logic [1:0]  ofs;
        start_errs = errors;
        for (int w = 0; w < 16; w++)        // Known contents first
        begin
            ref_code[w] = next_rand();
            ref_data[w] = next_rand();
            bus_write(CODE_BASE + 32'(w * 4), 3'd2, ref_code[w]);
            bus_write(DATA_BASE + 32'(w * 4), 3'd2, ref_data[w]);
        end
        for (int n = 0; n < 48; n++)
        begin
            r    = next_rand();
            data = next_rand();
            word = r[3:0];
            size = (r[5:4] == 2'd0) ? 3'd0 : (r[5:4] == 2'd1) ? 3'd1 : 3'd2;
            ofs  = (size == 3'd0) ? r[7:6] : (size == 3'd1) ? {r[7], 1'b0} : 2'd0;
            if (r[8])
            begin
                bus_write(DATA_BASE + {26'b0, word, ofs}, size, data);
                ref_data[word] = merge_lanes(ref_data[word], data, lanes_for(size, ofs));
            end
            else
            begin
                bus_write(CODE_BASE + {26'b0, word, ofs}, size, data);
                ref_code[word] = merge_lanes(ref_code[word], data, lanes_for(size, ofs));
            end
            bus_read(CODE_BASE + {26'b0, word, 2'b00}, got);   // Both RAMs at this offset
            check(got, ref_code[word], "code RAM readback");
            bus_read(DATA_BASE + {26'b0, word, 2'b00}, got);
            check(got, ref_data[word], "data RAM readback");
        end
        report_test("ram_access", start_errs);
    endtask

    task automatic pipelined_and_unmapped();
        int          start_errs;
        logic [31:0] r, data, got;
        logic [3:0]  word;
        start_errs = errors;
        for (int n = 0; n < 8; n++)
        begin
            r    = next_rand();
            data = next_rand();
            word = r[3:0];
            write_then_read(DATA_BASE + {26'b0, word, 2'b00}, data, got);
            ref_data[word] = data;
            check(got, data, "read right after write");
        end
        bus_read(HOLE_BASE + {26'b0, word, 2'b00}, got);
        check(got, 32'h0, "unmapped read");
        bus_write(HOLE_BASE + {26'b0, word, 2'b00}, 3'd2, ~ref_data[word]);
        bus_read(CODE_BASE + {26'b0, word, 2'b00}, got);
        check(got, ref_code[word], "code RAM after unmapped write");
        bus_read(DATA_BASE + {26'b0, word, 2'b00}, got);
        check(got, ref_data[word], "data RAM after unmapped write");
        report_test("pipelined_and_unmapped", start_errs);
    endtask

    task automatic gpio_regs();
        int          start_errs;
        logic [31:0] r, d, got, out_exp;
        logic [1:0]  lane;
        start_errs = errors;
        out_exp = next_rand();
        bus_write(GPIO_BASE + 32'(soc_pkg::GPIO_OUT_OFS), 3'd2, out_exp);
        check(gpio_out, 32'h0, "gpio_out before write lands");
        @(negedge clk);
        check(gpio_out, out_exp, "gpio_out after write");
        r = next_rand();
        bus_write(GPIO_BASE + 32'(soc_pkg::GPIO_OE_OFS), 3'd2, r);
        @(negedge clk);
        check(gpio_oe, r, "gpio_oe after write");
        bus_read(GPIO_BASE + 32'(soc_pkg::GPIO_OUT_OFS), got);
        check(got, out_exp, "gpio out register readback");
        bus_read(GPIO_BASE + 32'(soc_pkg::GPIO_OE_OFS), got);
        check(got, r, "gpio enable register readback");
        // Single lane update
        d    = next_rand();
        lane = d[25:24];
        bus_write(GPIO_BASE + 32'(soc_pkg::GPIO_OUT_OFS) + 32'(lane), 3'd0, d);
        out_exp = merge_lanes(out_exp, d, lanes_for(3'd0, lane));
        @(negedge clk);
        check(gpio_out, out_exp, "gpio_out after byte write");
        bus_read(GPIO_BASE + 32'(soc_pkg::GPIO_OUT_OFS), got);
        check(got, out_exp, "gpio byte write readback");
        // Input seen through two sync flops
        r       = next_rand();
        gpio_in = r;
        @(negedge clk);
        bus_read(GPIO_BASE + 32'(soc_pkg::GPIO_IN_OFS), got);
        check(got, r, "gpio input register");
        report_test("gpio_regs", start_errs);
    endtask

    task automatic uart_transmit();
        int          start_errs, waited, lows;
        logic [31:0] r, stat;
        logic [9:0]  line;
        start_errs = errors;
        r    = next_rand();
        line = '1;
        check(32'(txd), 32'd1, "txd idle");
        bus_write(UART_BASE + 32'(soc_pkg::UART_DATA_OFS), 3'd0, {24'b0, r[7:0]});
        fork
            begin
                waited = 0;
                while (txd && waited < 4 * CLKS_PER_BIT)    // Hunt for the start edge
                begin
                    @(negedge clk);
                    waited++;
                end
                if (txd)
                begin
                    errors++;
                    $display("ERROR at %0t ns: no start bit appeared on txd", $time);
                end
                repeat (CLKS_PER_BIT / 2 - 1) @(negedge clk);   // Start bit centre
                line[0] = txd;
                for (int i = 1; i < 10; i++)
                begin
                    repeat (CLKS_PER_BIT) @(negedge clk);
                    line[i] = txd;
                end
            end
            begin
                bus_read(UART_BASE + 32'(soc_pkg::UART_STAT_OFS), stat);
                check(stat & 32'h1, 32'h1, "status busy after data write");
                bus_write(UART_BASE + 32'(soc_pkg::UART_DATA_OFS), 3'd0, {24'b0, r[15:8]});
            end
        join
        check(32'(line), {22'b0, 1'b1, r[7:0], 1'b0}, "txd frame");
        stat = 32'h1;
        for (int i = 0; i < 2 * CLKS_PER_BIT && stat[0]; i++)
            bus_read(UART_BASE + 32'(soc_pkg::UART_STAT_OFS), stat);
        check(stat & 32'h1, 32'h0, "status idle after frame");
        lows = 0;
        repeat (10 * CLKS_PER_BIT)          // Byte written while busy must not go out
        begin
            @(negedge clk);
            if (!txd)
                lows++;
        end
        check(32'(lows), 32'd0, "txd activity after write while busy");
        report_test("uart_transmit", start_errs);
    endtask

    task automatic uart_receive();
        int          start_errs, waited, highs;
        logic [31:0] r, got;
        start_errs = errors;
        r = next_rand();
        check(32'(irq), 32'd0, "irq idle before frame");
        send_frame(r[7:0], 1'b1);
        waited = 0;
        while (!irq && waited < 10 * CLKS_PER_BIT)
        begin
            @(negedge clk);
            waited++;
        end
        check(32'(irq), 32'd1, "irq within a frame of the stop bit");
        repeat (CLKS_PER_BIT) @(negedge clk);   // Rest of the stop bit
        bus_read(UART_BASE + 32'(soc_pkg::UART_STAT_OFS), got);
        check(got & 32'h2, 32'h2, "status rx_valid");
        bus_read(UART_BASE + 32'(soc_pkg::UART_DATA_OFS), got);
        check(got, {24'b0, r[7:0]}, "received byte");
        @(negedge clk);
        check(32'(irq), 32'd0, "irq after data read");
        // Framing error
        send_frame(r[15:8], 1'b0);
        highs = 0;
        for (int i = 0; i < 20 * CLKS_PER_BIT; i++)
        begin
            @(negedge clk);
            if (i == CLKS_PER_BIT - 1)
                rxd = 1'b1;                 // Low stop bit lasted one bit time
            if (irq)
                highs++;
        end
        check(32'(highs), 32'd0, "irq after frame with low stop bit");
        report_test("uart_receive", start_errs);
    endtask

    // --------------------------------------------------
    // Sequence and watchdog
    // --------------------------------------------------
    initial
    begin
        clk     = 1'b0;
        RSTn    = 1'b0;
        haddr   = '0;
        htrans  = soc_pkg::TRANS_IDLE;
        hsize   = 3'd2;
        hwrite  = 1'b0;
        hwdata  = '0;
        rxd     = 1'b1;                     // Line idle
        gpio_in = '0;
        seed    = 32'hb0ed_2ee2;
        errors  = 0;
        checks  = 0;
        tests   = 0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        RSTn = 1'b1;
        ram_access();
        pipelined_and_unmapped();
        gpio_regs();
        uart_transmit();
        uart_receive();
        $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("Timeout after %0d ns, the tests did not complete", WATCHDOG_NS);
        $display("Regression failed");
        $finish;
    end

endmodule
